//--- isaPkg.sv
package isaPkg;

	// Primary opcodes
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] opCop0 = 6'h10;
	localparam logic [5:0] opLh = 6'h21;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opLhu = 6'h25;
	localparam logic [5:0] opSh = 6'h29;
	localparam logic [5:0] opSw = 6'h2b;

	// SPECIAL function codes
	localparam logic [5:0] functJr = 6'h08;
	localparam logic [5:0] functAdd = 6'h20;
	localparam logic [5:0] functAddu = 6'h21;

	localparam logic [31:0] eretWord = 32'h4200_0018;

	// Cause.ExcCode values, excNone marks an empty slot
	localparam logic [4:0] excAdEL = 5'd4;
	localparam logic [4:0] excAdES = 5'd5;
	localparam logic [4:0] excOv = 5'd12;
	localparam logic [4:0] excNone = 5'd15;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFormat;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm16;
	} iFormat;

	typedef union packed {
		rFormat rFields;
		iFormat iFields;
	} instrWord;

endpackage

//--- pipePkg.sv
package pipePkg;

	// Access width of a load or store
	typedef enum logic [1:0] {
		sizeWord,
		sizeHalf,
		sizeHalfU
	} memSize;

	// aluAdd traps on signed overflow, aluAddu never does
	typedef enum logic [1:0] {
		aluAdd,
		aluAddu,
		aluOr
	} aluOp;

	// Source of the write-back value
	typedef enum logic {
		wbAlu,
		wbMem
	} wbSrc;

endpackage

//--- fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit #(
	parameter logic [31:0] resetPc = 32'h0000_3000
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        instrValid,
	input  logic [31:0] instr,
	input  logic        stall,
	input  logic        redirectValid,
	input  logic [31:0] redirectPc,
	input  logic        flush,
	input  logic [31:0] excRedirectPc,
	output logic [31:0] fetchPc,
	output logic        instrReady,
	output logic        idValid,
	output logic [31:0] idInstr,
	output logic [31:0] idPc,
	output logic        idExc
);
	logic started;
	logic adelSent;
	logic pcBad;
	logic take;

	assign pcBad = fetchPc[1:0] != 2'b00;
	// No fetch while the PC is about to move or cannot be fetched
	assign instrReady = started && !stall && !flush && !redirectValid && !pcBad;
	assign take = instrValid && instrReady;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fetchPc <= resetPc;
			started <= 1'b0;
			adelSent <= 1'b0;
			idValid <= 1'b0;
			idExc <= 1'b0;
		end else begin
			started <= 1'b1;
			if (flush || redirectValid) begin
				fetchPc <= flush ? excRedirectPc : redirectPc;
				adelSent <= 1'b0;
				idValid <= 1'b0;
				idExc <= 1'b0;
			end else if (!stall) begin
				idValid <= take;
				// One AdEL bubble per misaligned target
				idExc <= pcBad && !adelSent;
				adelSent <= pcBad;
				if (take)
					fetchPc <= fetchPc + 32'd4;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			idInstr <= instr;
			idPc <= fetchPc;
		end
	end

endmodule

//--- regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic        clk,
	input  logic        rst,
	input  logic [4:0]  rdAddrA,
	input  logic [4:0]  rdAddrB,
	input  logic        wrEn,
	input  logic [4:0]  wrAddr,
	input  logic [31:0] wrData,
	output logic [31:0] rdDataA,
	output logic [31:0] rdDataB
);
	logic [31:0] regs [32];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'd0;
		end else if (wrEn && wrAddr != 5'd0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Write-through so decode sees the value retiring this cycle
	assign rdDataA = (rdAddrA == 5'd0) ? 32'd0 :
		(wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
	assign rdDataB = (rdAddrB == 5'd0) ? 32'd0 :
		(wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

//--- decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
	input  logic             clk,
	input  logic             rst,
	input  logic             flush,
	input  logic             idValid,
	input  logic [31:0]      idInstr,
	input  logic [31:0]      idPc,
	input  logic             idExc,
	input  logic [31:0]      rdDataA,
	input  logic [31:0]      rdDataB,
	input  logic [4:0]       memDest,
	input  logic [4:0]       wbDest,
	output logic [4:0]       rdAddrA,
	output logic [4:0]       rdAddrB,
	output logic             stall,
	output logic             redirectValid,
	output logic [31:0]      redirectPc,
	output logic             exValid,
	output pipePkg::aluOp    exAluOp,
	output logic             exMemRd,
	output logic             exMemWr,
	output pipePkg::memSize  exMemSize,
	output pipePkg::wbSrc    exWbSrc,
	output logic [4:0]       exDest,
	output logic [31:0]      exOpA,
	output logic [31:0]      exOpB,
	output logic [31:0]      exStoreData,
	output logic [31:0]      exPc,
	output logic             exExc,
	output logic [4:0]       exExcCode,
	output logic             exEret
);
	import isaPkg::*;
	import pipePkg::*;

	instrWord iw;
	logic known, useRs, useRt, isJr, isEret, memRd, memWr;
	logic rsHit, rtHit, issue;
	logic [4:0] dest;
	logic [31:0] signImm, zeroImm, opB;
	aluOp decAlu;
	memSize decSize;
	wbSrc decSrc;

	assign iw = idInstr;
	assign rdAddrA = iw.rFields.rs;
	assign rdAddrB = iw.rFields.rt;
	assign signImm = {{16{iw.iFields.imm16[15]}}, iw.iFields.imm16};
	assign zeroImm = {16'h0000, iw.iFields.imm16};

	always_comb begin
		known = 1'b0;
		useRs = 1'b1;
		useRt = 1'b0;
		isJr = 1'b0;
		isEret = 1'b0;
		memRd = 1'b0;
		memWr = 1'b0;
		dest = 5'd0;
		opB = signImm;
		decAlu = aluAddu;
		decSize = sizeWord;
		decSrc = wbAlu;
		case (iw.iFields.opcode)
			opSpecial: begin
				opB = rdDataB;
				case (iw.rFields.funct)
					functAdd, functAddu: begin
						known = 1'b1;
						useRt = 1'b1;
						dest = iw.rFields.rd;
						if (iw.rFields.funct == functAdd)
							decAlu = aluAdd;
					end
					functJr: begin
						known = 1'b1;
						isJr = 1'b1;
					end
					default: ;
				endcase
			end
			opAddi, opOri: begin
				known = 1'b1;
				dest = iw.iFields.rt;
				if (iw.iFields.opcode == opAddi)
					decAlu = aluAdd;
				else begin
					decAlu = aluOr;
					opB = zeroImm;
				end
			end
			opLw, opLh, opLhu: begin
				known = 1'b1;
				memRd = 1'b1;
				decSrc = wbMem;
				dest = iw.iFields.rt;
				if (iw.iFields.opcode == opLh)
					decSize = sizeHalf;
				else if (iw.iFields.opcode == opLhu)
					decSize = sizeHalfU;
			end
			opSw, opSh: begin
				known = 1'b1;
				useRt = 1'b1;
				memWr = 1'b1;
				if (iw.iFields.opcode == opSh)
					decSize = sizeHalf;
			end
			opCop0: begin
				useRs = 1'b0;
				if (iw == eretWord) begin
					known = 1'b1;
					isEret = 1'b1;
				end
			end
			default: ;
		endcase
	end

	// Interlock on any pending write, no forwarding paths
	assign rsHit = useRs && rdAddrA != 5'd0 &&
		(rdAddrA == exDest || rdAddrA == memDest || rdAddrA == wbDest);
	assign rtHit = useRt && rdAddrB != 5'd0 &&
		(rdAddrB == exDest || rdAddrB == memDest || rdAddrB == wbDest);
	assign stall = idValid && known && (rsHit || rtHit);

	assign redirectValid = idValid && isJr && !stall;
	assign redirectPc = rdDataA;
	assign issue = idValid && known && !isJr && !stall;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			exValid <= 1'b0;
			exMemRd <= 1'b0;
			exMemWr <= 1'b0;
			exDest <= 5'd0;
			exExc <= 1'b0;
			exExcCode <= excNone;
			exEret <= 1'b0;
		end else begin
			exValid <= !flush && (issue || idExc);
			exMemRd <= !flush && issue && memRd;
			exMemWr <= !flush && issue && memWr;
			exDest <= (!flush && issue) ? dest : 5'd0;
			exExc <= !flush && idExc;
			exExcCode <= (!flush && idExc) ? excAdEL : excNone;
			exEret <= !flush && issue && isEret;
		end
	end

	always_ff @(posedge clk) begin
		exAluOp <= decAlu;
		exMemSize <= decSize;
		exWbSrc <= decSrc;
		exOpA <= rdDataA;
		exOpB <= opB;
		exStoreData <= rdDataB;
		exPc <= idPc;
	end

endmodule

//--- executeStage.sv
`timescale 1ns/1ps

module executeStage (
	input  logic             clk,
	input  logic             rst,
	input  logic             flush,
	input  logic             exValid,
	input  pipePkg::aluOp    exAluOp,
	input  logic             exMemRd,
	input  logic             exMemWr,
	input  pipePkg::memSize  exMemSize,
	input  pipePkg::wbSrc    exWbSrc,
	input  logic [4:0]       exDest,
	input  logic [31:0]      exOpA,
	input  logic [31:0]      exOpB,
	input  logic [31:0]      exStoreData,
	input  logic [31:0]      exPc,
	input  logic             exExc,
	input  logic [4:0]       exExcCode,
	input  logic             exEret,
	output logic             memValid,
	output logic             memMemRd,
	output logic             memMemWr,
	output pipePkg::memSize  memMemSize,
	output pipePkg::wbSrc    memWbSrc,
	output logic [4:0]       memDest,
	output logic [31:0]      memResult,
	output logic [31:0]      memStoreData,
	output logic [31:0]      memPc,
	output logic             memExc,
	output logic [4:0]       memExcCode,
	output logic [31:0]      memBadVAddr,
	output logic             memEret
);
	import isaPkg::*;
	import pipePkg::*;

	logic [31:0] sum, result, bad;
	logic ov, misaligned, excAny;
	logic [4:0] code;

	assign sum = exOpA + exOpB;
	assign result = (exAluOp == aluOr) ? (exOpA | exOpB) : sum;
	// Same operand signs, different result sign
	assign ov = exValid && exAluOp == aluAdd && exOpA[31] == exOpB[31] && sum[31] != exOpA[31];
	assign misaligned = (exMemSize == sizeWord) ? (sum[1:0] != 2'b00) : sum[0];

	// Earlier stage first, then Ov, AdES, AdEL
	always_comb begin
		excAny = 1'b1;
		code = excNone;
		bad = exPc;
		if (exExc)
			code = exExcCode;
		else if (ov)
			code = excOv;
		else if (exMemWr && misaligned) begin
			code = excAdES;
			bad = sum;
		end else if (exMemRd && misaligned) begin
			code = excAdEL;
			bad = sum;
		end else
			excAny = 1'b0;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			memValid <= 1'b0;
			memMemRd <= 1'b0;
			memMemWr <= 1'b0;
			memDest <= 5'd0;
			memExc <= 1'b0;
			memExcCode <= excNone;
			memEret <= 1'b0;
		end else begin
			memValid <= !flush && exValid;
			memMemRd <= !flush && exMemRd && !excAny;
			memMemWr <= !flush && exMemWr && !excAny;
			memDest <= (!flush && !excAny) ? exDest : 5'd0;
			memExc <= !flush && excAny;
			memExcCode <= flush ? excNone : code;
			memEret <= !flush && exEret && !excAny;
		end
	end

	always_ff @(posedge clk) begin
		memMemSize <= exMemSize;
		memWbSrc <= exWbSrc;
		memResult <= result;
		memStoreData <= exStoreData;
		memPc <= exPc;
		memBadVAddr <= bad;
	end

endmodule

//--- memStage.sv
`timescale 1ns/1ps

module memStage #(
	parameter int dataWords = 64
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             memValid,
	input  logic             memMemRd,
	input  logic             memMemWr,
	input  pipePkg::memSize  memMemSize,
	input  pipePkg::wbSrc    memWbSrc,
	input  logic [4:0]       memDest,
	input  logic [31:0]      memResult,
	input  logic [31:0]      memStoreData,
	input  logic             memExc,
	output logic             wbValid,
	output logic [4:0]       wbReg,
	output logic [31:0]      wbData,
	output logic [4:0]       wbDest
);
	import pipePkg::*;

	localparam int addrBits = $clog2(dataWords);

	logic [31:0] ram [dataWords];
	logic [addrBits-1:0] idx;
	logic [31:0] rdWord, loadData;
	logic [15:0] half;

	assign idx = memResult[addrBits+1:2];
	assign rdWord = ram[idx];
	// Little-endian halves, address bit 1 picks the upper one
	assign half = memResult[1] ? rdWord[31:16] : rdWord[15:0];

	always_comb begin
		case (memMemSize)
			sizeHalf: loadData = {{16{half[15]}}, half};
			sizeHalfU: loadData = {16'h0000, half};
			default: loadData = rdWord;
		endcase
	end

	always_ff @(posedge clk) begin
		if (memValid && memMemWr) begin
			if (memMemSize == sizeWord)
				ram[idx] <= memStoreData;
			else if (memResult[1])
				ram[idx][31:16] <= memStoreData[15:0];
			else
				ram[idx][15:0] <= memStoreData[15:0];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			wbValid <= 1'b0;
		else
			wbValid <= memValid && !memExc && memDest != 5'd0;
	end

	always_ff @(posedge clk) begin
		wbReg <= memDest;
		wbData <= (memMemRd && memWbSrc == wbMem) ? loadData : memResult;
	end

	assign wbDest = wbValid ? wbReg : 5'd0;

endmodule

//--- excCtrl.sv
`timescale 1ns/1ps

module excCtrl #(
	parameter logic [31:0] excVector = 32'h0000_4180
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        memValid,
	input  logic        memExc,
	input  logic [4:0]  memExcCode,
	input  logic [31:0] memBadVAddr,
	input  logic [31:0] memPc,
	input  logic        memEret,
	output logic        flush,
	output logic [31:0] excRedirectPc,
	output logic        excTaken,
	output logic [4:0]  excCode,
	output logic [31:0] epc,
	output logic [31:0] badVAddr,
	output logic        exl
);
	import isaPkg::*;

	logic takeExc;
	logic takeEret;

	assign takeExc = memValid && memExc;
	assign takeEret = memValid && memEret;
	assign flush = takeExc || takeEret;
	assign excRedirectPc = takeExc ? excVector : epc;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			excTaken <= 1'b0;
			exl <= 1'b0;
			excCode <= excNone;
			epc <= 32'd0;
			badVAddr <= 32'd0;
		end else begin
			excTaken <= takeExc;
			if (takeExc) begin
				exl <= 1'b1;
				excCode <= memExcCode;
				badVAddr <= memBadVAddr;
				// EPC keeps the first fault while the handler runs
				if (!exl)
					epc <= memPc;
			end else if (takeEret) begin
				exl <= 1'b0;
			end
		end
	end

endmodule

//--- excPipe.sv
`timescale 1ns/1ps

module excPipe #(
	parameter logic [31:0] resetPc = 32'h0000_3000,
	parameter logic [31:0] excVector = 32'h0000_4180,
	parameter int dataWords = 64
) (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] instr,
	input  logic        instrValid,
	output logic [31:0] fetchPc,
	output logic        instrReady,
	output logic        wbValid,
	output logic [4:0]  wbReg,
	output logic [31:0] wbData,
	output logic        excTaken,
	output logic [4:0]  excCode,
	output logic [31:0] epc,
	output logic [31:0] badVAddr
);
	import pipePkg::*;

	logic idValid, idExc, stall, redirectValid, flush, exl;
	logic [31:0] idInstr, idPc, redirectPc, excRedirectPc;
	logic [4:0] rdAddrA, rdAddrB, wbDest;
	logic [31:0] rdDataA, rdDataB;

	logic exValid, exMemRd, exMemWr, exExc, exEret;
	aluOp exAluOp;
	memSize exMemSize;
	wbSrc exWbSrc;
	logic [4:0] exDest, exExcCode;
	logic [31:0] exOpA, exOpB, exStoreData, exPc;

	logic memValid, memMemRd, memMemWr, memExc, memEret;
	memSize memMemSize;
	wbSrc memWbSrc;
	logic [4:0] memDest, memExcCode;
	logic [31:0] memResult, memStoreData, memPc, memBadVAddr;

	fetchUnit #(.resetPc(resetPc)) uFetch (.*);

	regFile uRegs (.wrEn(wbValid), .wrAddr(wbReg), .wrData(wbData), .*);

	decodeStage uDecode (.*);

	executeStage uExecute (.*);

	memStage #(.dataWords(dataWords)) uMem (.*);

	excCtrl #(.excVector(excVector)) uExc (.*);

endmodule

//--- excPipe_asserts.sv
`timescale 1ns/1ps

module excPipe_asserts (
	input logic clk,
	input logic rst,
	input logic excTaken,
	input logic wbValid,
	input logic memValid,
	input logic memEret,
	input logic exl
);

	int failCount = 0;

	// Flush clears EX/MEM, so a second report cannot follow
	excSingle: assert property (@(posedge clk) disable iff (rst)
		excTaken |=> !excTaken)
		else begin
			$error("excTaken high in two consecutive cycles");
			failCount++;
		end

	// Faulting instruction and its followers never retire
	excNoWb: assert property (@(posedge clk) disable iff (rst)
		excTaken |-> !wbValid ##1 !wbValid)
		else begin
			$error("write-back seen right after an exception");
			failCount++;
		end

	// eret only returns from a running handler
	eretInHandler: assert property (@(posedge clk) disable iff (rst)
		memValid && memEret |-> exl)
		else begin
			$error("eret reached EX/MEM while EXL was clear");
			failCount++;
		end

endmodule

//--- tb_excPipe.sv
`timescale 1ns/1ps

module tb_excPipe;
	import isaPkg::*;

	localparam logic [31:0] handlerPc = 32'h0000_4180;

	logic clk;
	logic rst;
	logic [31:0] instr;
	logic instrValid;
	logic [31:0] fetchPc;
	logic instrReady;
	logic wbValid;
	logic [4:0] wbReg;
	logic [31:0] wbData;
	logic excTaken;
	logic [4:0] excCode;
	logic [31:0] epc;
	logic [31:0] badVAddr;

	// Program rows and expected write-backs, tagged with their case
	int progCase[$];
	logic [31:0] progPc[$];
	logic [31:0] progWord[$];
	int wbCase[$];
	logic [4:0] wbRegTab[$];
	logic [31:0] wbValTab[$];
	logic [4:0] excCodeTab[$];
	logic [31:0] excEpcTab[$];
	logic [31:0] excBadTab[$];

	logic [31:0] curPc[$];
	logic [31:0] curWord[$];
	logic [4:0] curReg[$];
	logic [31:0] curVal[$];

	int numTests = 0;
	int errorCount = 0;
	int casesPassed = 0;
	int casesFailed = 0;
	int cycles = 0;
	int cycleLimit = 0;

	excPipe i_dut (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.instrValid(instrValid),
		.fetchPc(fetchPc),
		.instrReady(instrReady),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.excTaken(excTaken),
		.excCode(excCode),
		.epc(epc),
		.badVAddr(badVAddr)
	);

	bind excPipe excPipe_asserts uAsserts (
		.clk(clk),
		.rst(rst),
		.excTaken(excTaken),
		.wbValid(wbValid),
		.memValid(memValid),
		.memEret(memEret),
		.exl(exl)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycleLimit > 0 && cycles > cycleLimit) begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("Test FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] encodeImm(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
			logic [15:0] imm);
		instrWord w;
		w.iFields.opcode = op;
		w.iFields.rs = rs;
		w.iFields.rt = rt;
		w.iFields.imm16 = imm;
		return w;
	endfunction

	function automatic logic [31:0] encodeReg(logic [5:0] funct, logic [4:0] rs, logic [4:0] rt,
			logic [4:0] rd);
		instrWord w;
		w.rFields.opcode = opSpecial;
		w.rFields.rs = rs;
		w.rFields.rt = rt;
		w.rFields.rd = rd;
		w.rFields.shamt = 5'd0;
		w.rFields.funct = funct;
		return w;
	endfunction

	task automatic startCase();
		numTests++;
		excCodeTab.push_back(excNone);
		excEpcTab.push_back(32'd0);
		excBadTab.push_back(32'd0);
	endtask

	task automatic instrAt(logic [31:0] pc, logic [31:0] word);
		progCase.push_back(numTests - 1);
		progPc.push_back(pc);
		progWord.push_back(word);
	endtask

	task automatic wbExpect(logic [4:0] r, logic [31:0] v);
		wbCase.push_back(numTests - 1);
		wbRegTab.push_back(r);
		wbValTab.push_back(v);
	endtask

	task automatic excExpect(logic [4:0] code, logic [31:0] pc, logic [31:0] bad);
		excCodeTab[numTests - 1] = code;
		excEpcTab[numTests - 1] = pc;
		excBadTab[numTests - 1] = bad;
	endtask

	task automatic defineTests();
		// Dependent ALU chain
		startCase();
		instrAt(32'h3000, encodeImm(opAddi, 0, 1, 16'd5));
		instrAt(32'h3004, encodeImm(opOri, 1, 2, 16'h0030));
		instrAt(32'h3008, encodeReg(functAddu, 1, 2, 3));
		instrAt(32'h300c, encodeImm(opAddi, 3, 4, 16'hfff6));
		instrAt(32'h3010, encodeReg(functAddu, 4, 4, 5));
		wbExpect(1, 32'd5);
		wbExpect(2, 32'd5 | 32'h30);
		wbExpect(3, 32'd5 + 32'h35);
		wbExpect(4, 32'h3a - 32'd10);
		wbExpect(5, 32'h30 + 32'h30);
		// 0x7fffffff + 1 overflows, younger work is dropped
		startCase();
		instrAt(32'h3000, encodeImm(opOri, 0, 1, 16'h7fff));
		instrAt(32'h3004, encodeImm(opOri, 0, 2, 16'hffff));
		instrAt(32'h3008, encodeImm(opSh, 0, 1, 16'h0022));
		instrAt(32'h300c, encodeImm(opSh, 0, 2, 16'h0020));
		instrAt(32'h3010, encodeImm(opLw, 0, 3, 16'h0020));
		instrAt(32'h3014, encodeImm(opOri, 0, 6, 16'h0001));
		instrAt(32'h3018, encodeReg(functAdd, 3, 6, 5));
		instrAt(32'h301c, encodeImm(opOri, 0, 7, 16'h0077));
		instrAt(32'h3020, encodeReg(functAddu, 1, 1, 8));
		instrAt(handlerPc, encodeImm(opOri, 0, 31, 16'h00e0));
		wbExpect(1, 32'h0000_7fff);
		wbExpect(2, 32'h0000_ffff);
		wbExpect(3, 32'h7fff_ffff);
		wbExpect(6, 32'd1);
		wbExpect(31, 32'h0000_00e0);
		excExpect(excOv, 32'h3018, 32'h3018);
		// Word and half accesses, then a misaligned sh
		startCase();
		instrAt(32'h3000, encodeImm(opAddi, 0, 1, 16'h8765));
		instrAt(32'h3004, encodeImm(opOri, 0, 2, 16'h1234));
		instrAt(32'h3008, encodeImm(opSw, 0, 1, 16'h0040));
		instrAt(32'h300c, encodeImm(opLw, 0, 3, 16'h0040));
		instrAt(32'h3010, encodeImm(opSh, 0, 1, 16'h0046));
		instrAt(32'h3014, encodeImm(opLh, 0, 4, 16'h0046));
		instrAt(32'h3018, encodeImm(opLhu, 0, 5, 16'h0046));
		instrAt(32'h301c, encodeImm(opSh, 0, 2, 16'h0044));
		instrAt(32'h3020, encodeImm(opLw, 0, 6, 16'h0044));
		instrAt(32'h3024, encodeImm(opSh, 0, 2, 16'h0049));
		instrAt(32'h3028, encodeImm(opOri, 0, 7, 16'h0001));
		instrAt(handlerPc, encodeImm(opOri, 0, 31, 16'h00e3));
		wbExpect(1, 32'hffff_8765);
		wbExpect(2, 32'h0000_1234);
		wbExpect(3, 32'hffff_8765);
		wbExpect(4, 32'hffff_8765);
		wbExpect(5, 32'h0000_8765);
		wbExpect(6, 32'h8765_1234);
		wbExpect(31, 32'h0000_00e3);
		excExpect(excAdES, 32'h3024, 32'h49);
		// Misaligned lw
		startCase();
		instrAt(32'h3000, encodeImm(opOri, 0, 1, 16'h0011));
		instrAt(32'h3004, encodeImm(opLw, 1, 2, 16'h0002));
		instrAt(handlerPc, encodeImm(opOri, 0, 31, 16'h00e1));
		wbExpect(1, 32'h11);
		wbExpect(31, 32'he1);
		excExpect(excAdEL, 32'h3004, 32'h13);
		// jr to a misaligned target
		startCase();
		instrAt(32'h3000, encodeImm(opOri, 0, 1, 16'h3102));
		instrAt(32'h3004, encodeReg(functJr, 1, 0, 0));
		instrAt(32'h3008, encodeImm(opOri, 0, 9, 16'h0009));
		instrAt(handlerPc, encodeImm(opOri, 0, 31, 16'h00e2));
		wbExpect(1, 32'h3102);
		wbExpect(31, 32'he2);
		excExpect(excAdEL, 32'h3102, 32'h3102);
		// Handler fixes the operand, eret retries the addi
		startCase();
		instrAt(32'h3000, encodeImm(opOri, 0, 1, 16'h7fff));
		instrAt(32'h3004, encodeImm(opOri, 0, 2, 16'hffff));
		instrAt(32'h3008, encodeImm(opSh, 0, 1, 16'h0032));
		instrAt(32'h300c, encodeImm(opSh, 0, 2, 16'h0030));
		instrAt(32'h3010, encodeImm(opLw, 0, 3, 16'h0030));
		instrAt(32'h3014, encodeImm(opAddi, 3, 4, 16'h0001));
		instrAt(32'h3018, encodeImm(opOri, 0, 5, 16'h0055));
		instrAt(handlerPc, encodeImm(opOri, 0, 3, 16'h0100));
		instrAt(handlerPc + 32'd4, eretWord);
		wbExpect(1, 32'h0000_7fff);
		wbExpect(2, 32'h0000_ffff);
		wbExpect(3, 32'h7fff_ffff);
		wbExpect(3, 32'h0000_0100);
		wbExpect(4, 32'h100 + 32'd1);
		wbExpect(5, 32'h55);
		excExpect(excOv, 32'h3014, 32'h3014);
	endtask

	function automatic logic [31:0] wordAt(logic [31:0] pc);
		for (int i = 0; i < curPc.size(); i++)
			if (curPc[i] == pc)
				return curWord[i];
		// Zero decodes as a bubble
		return 32'd0;
	endfunction

	task automatic loadCase(int t);
		curPc.delete();
		curWord.delete();
		curReg.delete();
		curVal.delete();
		for (int i = 0; i < progPc.size(); i++)
			if (progCase[i] == t) begin
				curPc.push_back(progPc[i]);
				curWord.push_back(progWord[i]);
			end
		for (int i = 0; i < wbRegTab.size(); i++)
			if (wbCase[i] == t) begin
				curReg.push_back(wbRegTab[i]);
				curVal.push_back(wbValTab[i]);
			end
	endtask

	task automatic resetDut();
		rst = 1'b1;
		instrValid = 1'b0;
		instr = 32'd0;
		repeat (2) @(posedge clk);
		#2;
		assert (!wbValid && !excTaken && !instrReady)
			else begin
				$display("[ERROR] %0t: outputs not low during reset", $time);
				errorCount++;
			end
		rst = 1'b0;
	endtask

	task automatic driveFetch(bit gaps);
		instr = wordAt(fetchPc);
		instrValid = gaps ? ($urandom % 4 != 0) : 1'b1;
	endtask

	task automatic runCase(int t, bit gaps);
		int seen;
		int excSeen;
		int excWanted;
		int errBefore;
		seen = 0;
		excSeen = 0;
		errBefore = errorCount;
		excWanted = (excCodeTab[t] != excNone) ? 1 : 0;
		loadCase(t);
		resetDut();
		driveFetch(gaps);
		while (seen < curReg.size() || excSeen < excWanted) begin
			@(posedge clk);
			#2;
			if (wbValid) begin
				assert (seen < curReg.size())
					else begin
						$display("[ERROR] %0t: unexpected write-back to r%0d", $time, wbReg);
						errorCount++;
					end
				if (seen < curReg.size()) begin
					assert (wbReg == curReg[seen])
						else begin
							$display("[ERROR] %0t ns: wbReg = %0d, expected %0d",
								$time, wbReg, curReg[seen]);
							errorCount++;
						end
					assert (wbData == curVal[seen])
						else begin
							$display("[ERROR] %0t ns: wbData = 0x%08h, expected 0x%08h",
								$time, wbData, curVal[seen]);
							errorCount++;
						end
				end
				seen++;
			end
			if (excTaken) begin
				assert (excSeen < excWanted)
					else begin
						$display("[ERROR] %0t: exception with code %0d was not expected",
							$time, excCode);
						errorCount++;
					end
				if (excSeen < excWanted) begin
					assert (excCode == excCodeTab[t])
						else begin
							$display("[ERROR] %0t ns: excCode = %0d, expected %0d",
								$time, excCode, excCodeTab[t]);
							errorCount++;
						end
					assert (epc == excEpcTab[t])
						else begin
							$display("[ERROR] %0t ns: epc = 0x%08h, expected 0x%08h",
								$time, epc, excEpcTab[t]);
							errorCount++;
						end
					assert (badVAddr == excBadTab[t])
						else begin
							$display("[ERROR] %0t ns: badVAddr = 0x%08h, expected 0x%08h",
								$time, badVAddr, excBadTab[t]);
							errorCount++;
						end
				end
				excSeen++;
			end
			driveFetch(gaps);
		end
		if (errorCount == errBefore)
			casesPassed++;
		else
			casesFailed++;
		$display("case %0d, %s: %s, %0d write-backs, %0d exceptions", t + 1,
			gaps ? "random gaps" : "no gaps", (errorCount == errBefore) ? "pass" : "fail",
			seen, excSeen);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		instr = 32'd0;
		instrValid = 1'b0;
		void'($urandom(81));
		defineTests();
		// Two passes over the table
		cycleLimit = 2 * (progPc.size() + wbRegTab.size()) * 12 + 50;
		for (int pass = 0; pass < 2; pass++)
			for (int t = 0; t < numTests; t++)
				runCase(t, pass == 1);
		$display("cases run %0d, passed %0d, failed %0d, failed checks %0d",
			casesPassed + casesFailed, casesPassed, casesFailed,
			errorCount + i_dut.uAsserts.failCount);
		if (errorCount == 0 && casesFailed == 0 && i_dut.uAsserts.failCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

//--- compile.f
isaPkg.sv
pipePkg.sv
fetchUnit.sv
regFile.sv
decodeStage.sv
executeStage.sv
memStage.sv
excCtrl.sv
excPipe.sv
excPipe_asserts.sv
tb_excPipe.sv
